// File: filelist.f
+incdir+tb
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/core_top.sv
tb/tb_core.sv

// File: Makefile
TOP = tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --assert --timescale 1ns/100ps -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// architectural registers as the core should see them, x0 never written
xlen_t shadow [32];

// first 31 picks load x1..x31, the rest are random
function automatic xlen_t pick_instruction(int n);
    xlen_t    r;
    reg_idx_t rd, rs1, rs2;
    funct3_t  f3;
    r   = $urandom;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3  = 3'($urandom);
    if (n < 31) begin
        return {r[31:20], 5'd0, 3'b000, 5'(n + 1), OP_OP_IMM};  // addi xN, x0, imm
    end
    case ($urandom_range(9, 0))
        0, 1: begin
            r[30] = r[30] && (f3 == 3'b000 || f3 == 3'b101);  // sub and sra only
            return {1'b0, r[30], 5'b0, rs2, rs1, f3, rd, OP_OP};
        end
        2, 3: begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                r[31:25] = {1'b0, r[30] && f3 == 3'b101, 5'b0};   // shamt form
            end
            return {r[31:20], rs1, f3, rd, OP_OP_IMM};
        end
        4: return {r[31:12], rd, (r[0] ? OP_LUI : OP_AUIPC)};
        5: return {r[31:12], rd, OP_JAL};       // any 20 bits make a J offset
        6: return {r[31:20], rs1, 3'b000, rd, OP_JALR};
        7, 8: begin
            if (f3 == 3'b010 || f3 == 3'b011) begin
                f3 = f3 + 3'd4;     // reserved codes onto bltu / bgeu
            end
            if (r[1:0] == 2'b00) begin
                rs2 = rs1;  // equal operands now and then
            end
            return {r[31:25], rs2, rs1, f3, r[11:7], OP_BRANCH};
        end
        default: return {r[31:7], (r[0] ? 7'b0000011 : 7'b1110011)};  // load or system
    endcase
endfunction

// expected effect of one instruction at pc
task automatic model_step(input xlen_t inst, input xlen_t pc, output logic we,
                          output xlen_t data, output xlen_t next_pc);
    xlen_t a, b, imm_i, imm_b;
    logic  taken;
    a       = (inst[19:15] == '0) ? '0 : shadow[inst[19:15]];
    b       = (inst[24:20] == '0) ? '0 : shadow[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    we      = (inst[11:7] != '0);
    data    = pc + 32'd4;   // link value
    next_pc = pc + 32'd4;
    case (inst[6:0])
        OP_OP, OP_OP_IMM: begin
            if (!inst[5]) begin
                b = imm_i;
            end
            case (inst[14:12])
                3'b000:  data = (inst[5] && inst[30]) ? a - b : a + b;
                3'b001:  data = a << b[4:0];
                3'b010:  data = {31'b0, $signed(a) < $signed(b)};
                3'b011:  data = {31'b0, a < b};
                3'b100:  data = a ^ b;
                3'b101: begin
                    if (inst[30]) begin
                        data = $signed(a) >>> b[4:0];
                    end else begin
                        data = a >> b[4:0];
                    end
                end
                3'b110:  data = a | b;
                default: data = a & b;
            endcase
        end
        OP_LUI:   data = {inst[31:12], 12'b0};
        OP_AUIPC: data = pc + {inst[31:12], 12'b0};
        OP_JAL:   next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        OP_JALR:  next_pc = (a + imm_i) & ~32'd1;
        OP_BRANCH: begin
            we = 1'b0;
            case (inst[14:12])
                F3_BEQ:  taken = (a == b);
                F3_BNE:  taken = (a != b);
                F3_BLT:  taken = ($signed(a) < $signed(b));
                F3_BGE:  taken = ($signed(a) >= $signed(b));
                F3_BLTU: taken = (a < b);
                F3_BGEU: taken = (a >= b);
                default: taken = 1'b0;  // reserved codes never branch
            endcase
            if (taken) begin
                next_pc = pc + imm_b;
            end
        end
        default: we = 1'b0;     // no-op
    endcase
endtask

`endif

// File: tb/tb_core.sv
`timescale 1ns/100ps

module tb_core import rv_pkg::*; ();

    localparam int NUM_INSTS     = 431;   // 31 register loads, then 400 random
    localparam int MAX_ACK_DELAY = 3;
    localparam int MAX_CYCLES    = 4000;  // worst case about 4 cycles per instruction

    logic     clk;
    logic     reset;
    logic     ibus_cyc, ibus_stb, ibus_ack;
    xlen_t    ibus_adr, ibus_rdata;
    logic     retire_valid, retire_we;
    xlen_t    retire_pc, retire_data;
    reg_idx_t retire_rd;
    int       cycles = 0;

    `include "rv_model.svh"

    core_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the core did not finish the instruction stream in time");
            $display("TEST FAILED");
            $fatal(1, "timeout after %0d cycles", cycles);
        end
    end

    task automatic check_value(string name, xlen_t expected, xlen_t actual);
        assert (expected === actual) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // request held, nothing retiring
    task automatic check_idle(xlen_t exp_pc);
        check_value("ibus_cyc", 32'd1, 32'(ibus_cyc));
        check_value("ibus_stb", 32'd1, 32'(ibus_stb));
        check_value("retire_valid", 32'd0, 32'(retire_valid));
        check_value("ibus_adr", exp_pc, ibus_adr);
    endtask

    initial begin
        int    i, n, delay;
        xlen_t inst, exp_pc, exp_data, next_pc;
        logic  exp_we;
        void'($urandom(15));
        reset      <= 1'b1;
        ibus_ack   <= 1'b0;
        ibus_rdata <= '0;
        for (i = 1; i <= 8; i++) begin
            @(posedge clk);
            ibus_rdata <= $urandom;
            if (i == 8) begin
                reset    <= 1'b0;
                ibus_ack <= 1'b0;
            end else begin
                ibus_ack <= 1'b1;   // stray ack, no request yet
            end
            @(negedge clk);
            check_value("ibus_cyc", 32'd0, 32'(ibus_cyc));
            check_value("ibus_stb", 32'd0, 32'(ibus_stb));
            check_value("retire_valid", 32'd0, 32'(retire_valid));
        end
        @(posedge clk);
        @(negedge clk);
        exp_pc = RESET_PC;
        check_idle(exp_pc);
        for (n = 0; n < NUM_INSTS; n++) begin
            delay = $urandom_range(MAX_ACK_DELAY, 0);
            repeat (delay) begin
                @(posedge clk);
                ibus_ack   <= 1'b0;
                ibus_rdata <= $urandom;     // garbage while ack is low
                @(negedge clk);
                check_idle(exp_pc);
            end
            inst = pick_instruction(n);
            model_step(inst, exp_pc, exp_we, exp_data, next_pc);
            @(posedge clk);
            ibus_ack   <= 1'b1;
            ibus_rdata <= inst;
            @(negedge clk);
            check_value("retire_valid", 32'd1, 32'(retire_valid));
            check_value("ibus_adr", exp_pc, ibus_adr);
            check_value("retire_pc", exp_pc, retire_pc);
            check_value("retire_we", 32'(exp_we), 32'(retire_we));
            if (exp_we) begin
                check_value("retire_rd", 32'(inst[11:7]), 32'(retire_rd));
                check_value("retire_data", exp_data, retire_data);
                shadow[inst[11:7]] = exp_data;
            end
            exp_pc = next_pc;
        end
        @(posedge clk);
        ibus_ack   <= 1'b0;
        ibus_rdata <= $urandom;
        @(negedge clk);
        check_idle(exp_pc);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/100ps

module core_top import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output logic     ibus_cyc,
    output logic     ibus_stb,
    output xlen_t    ibus_adr,
    input  xlen_t    ibus_rdata,
    input  logic     ibus_ack,
    output logic     retire_valid,
    output xlen_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     retire_we,
    output xlen_t    retire_data
);
    xlen_t      pc, snpc;
    logic       retire;
    logic       redirect;
    xlen_t      redirect_pc;
    opcode_t    opcode;
    funct3_t    funct3;
    logic       funct7_alt;
    reg_idx_t   rs1, rs2, rd;
    xlen_t      imm;
    inst_kind_e kind;
    logic       rd_write;
    xlen_t      src1, src2;
    xlen_t      wb_data;
    logic       reg_we;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .ibus_ack   (ibus_ack),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .pc         (pc),
        .snpc       (snpc),
        .retire     (retire)
    );

    decoder u_dec (
        .inst      (ibus_rdata),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_alt(funct7_alt),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .kind      (kind),
        .rd_write  (rd_write)
    );

    assign reg_we = retire & rd_write;  // write only on the ack edge

    reg_file u_regs (
        .clk   (clk),
        .we    (reg_we),
        .waddr (rd),
        .wdata (wb_data),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(src1),
        .rdata2(src2)
    );

    alu_unit u_alu (
        .kind      (kind),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_alt(funct7_alt),
        .src1      (src1),
        .src2      (src2),
        .imm       (imm),
        .pc        (pc),
        .snpc      (snpc),
        .wb_data   (wb_data)
    );

    branch_unit u_br (
        .kind       (kind),
        .opcode     (opcode),
        .funct3     (funct3),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .pc         (pc),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    assign ibus_adr     = pc;
    assign retire_valid = retire;
    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_we    = reg_we;
    assign retire_data  = wb_data;

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/100ps

module branch_unit import rv_pkg::*; (
    input  inst_kind_e kind,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  xlen_t      src1,
    input  xlen_t      src2,
    input  xlen_t      imm,
    input  xlen_t      pc,
    output logic       redirect,
    output xlen_t      redirect_pc
);
    xlen_t jalr_sum;
    logic  taken;

    assign jalr_sum    = src1 + imm;
    assign redirect_pc = (opcode == OP_JALR) ? {jalr_sum[31:1], 1'b0} : pc + imm;

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (src1 == src2);
            F3_BNE:  taken = (src1 != src2);
            F3_BLT:  taken = ($signed(src1) < $signed(src2));
            F3_BGE:  taken = ($signed(src1) >= $signed(src2));
            F3_BLTU: taken = (src1 < src2);
            F3_BGEU: taken = (src1 >= src2);
            default: taken = 1'b0;  // reserved encodings fall through
        endcase
    end

    always_comb begin
        if (opcode == OP_JAL || opcode == OP_JALR) begin
            redirect = 1'b1;
        end else if (kind == KIND_B) begin
            redirect = taken;
        end else begin
            redirect = 1'b0;
        end
    end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/100ps

module alu_unit import rv_pkg::*; (
    input  inst_kind_e kind,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  logic       funct7_alt,
    input  xlen_t      src1,
    input  xlen_t      src2,
    input  xlen_t      imm,
    input  xlen_t      pc,
    input  xlen_t      snpc,
    output xlen_t      wb_data
);
    xlen_t   op_a, op_b;
    xlen_t   result;
    alu_op_e alu_op;

    always_comb begin
        case (kind)
            KIND_R: begin
                op_a = src1;
                op_b = src2;
            end
            KIND_I: begin
                op_a = src1;
                op_b = imm;
            end
            KIND_U: begin
                op_a = (opcode == OP_LUI) ? '0 : pc;    // lui vs auipc
                op_b = imm;
            end
            default: begin
                op_a = src1;
                op_b = src2;
            end
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;   // lui, auipc and jumps add
        if (opcode == OP_OP || opcode == OP_OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (kind == KIND_R && funct7_alt) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << op_b[4:0];
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_SRA:  result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;
        endcase
    end

    // link address for jal / jalr
    assign wb_data = (opcode == OP_JAL || opcode == OP_JALR) ? snpc : result;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);
    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/decoder.sv
`timescale 1ns/100ps

module decoder import rv_pkg::*; (
    input  xlen_t      inst,
    output opcode_t    opcode,
    output funct3_t    funct3,
    output logic       funct7_alt,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output xlen_t      imm,
    output inst_kind_e kind,
    output logic       rd_write
);
    assign opcode     = inst[6:0];
    assign rd         = inst[11:7];
    assign funct3     = inst[14:12];
    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];
    assign funct7_alt = inst[30];   // sub / sra select

    always_comb begin
        case (opcode)
            OP_OP:              kind = KIND_R;
            OP_OP_IMM, OP_JALR: kind = KIND_I;
            OP_LUI, OP_AUIPC:   kind = KIND_U;
            OP_JAL:             kind = KIND_J;
            OP_BRANCH:          kind = KIND_B;
            default:            kind = KIND_NONE;
        endcase
    end

    always_comb begin
        case (kind)
            KIND_I:  imm = {{20{inst[31]}}, inst[31:20]};
            KIND_U:  imm = {inst[31:12], 12'b0};
            KIND_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            KIND_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = '0;
        endcase
    end

    // x0 as destination never counts as a write
    always_comb begin
        case (kind)
            KIND_R, KIND_I, KIND_U, KIND_J: rd_write = (rd != '0);
            default:                        rd_write = 1'b0;
        endcase
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  ibus_ack,
    input  logic  redirect,
    input  xlen_t redirect_pc,
    output logic  ibus_cyc,
    output logic  ibus_stb,
    output xlen_t pc,
    output xlen_t snpc,
    output logic  retire
);
    logic req;

    // request stays up between transfers, one fetch in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            req <= 1'b0;
        end else begin
            req <= 1'b1;
        end
    end

    assign ibus_cyc = req;
    assign ibus_stb = req;
    assign retire   = req & ibus_ack;   // transfer completes this edge
    assign snpc     = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (retire) begin
            pc <= redirect ? redirect_pc : snpc;
        end
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] xlen_t;    // data or address word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam xlen_t RESET_PC = 32'h8000_0000;

    // major opcodes of the supported groups
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_OP_IMM = 7'b0010011;
    localparam opcode_t OP_OP     = 7'b0110011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [2:0] {
        KIND_R,
        KIND_I,     // op-imm and jalr
        KIND_U,
        KIND_J,
        KIND_B,
        KIND_NONE   // anything else retires as a no-op
    } inst_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage
